//--- tb.f
+incdir+.
lisp_pkg.sv
stack_alu.sv
stack_datapath.sv
stack_control.sv
lisp_core.sv
tb_lisp_mem.sv
tb_lisp_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_lisp_core -f tb.f -o tb_sim || exit 1
sim_output=$(./obj_dir/tb_sim)
printf '%s\n' "$sim_output"
printf '%s\n' "$sim_output" | grep -qx "test passed" && exit 0 || exit 1

//--- tb_lisp_core.sv
`default_nettype none

`include "lisp_settings.svh"

module tb_lisp_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam lisp_pkg::addr_t RESULT_ADDR = 16'h0100;
	// Stack spills stay far above this
	localparam lisp_pkg::addr_t STACK_FLOOR =
		lisp_pkg::addr_t'(`LISP_DATA_MEM_SIZE - `LISP_SP_RESET_GAP - 64);
	localparam int RESET_CYCLES = 16;
	localparam int RESULT_WAIT = 200;
	// 31 short runs of under 40 cycles each, with ample margin
	localparam int MAX_CYCLES = 1600;
	localparam lisp_pkg::value_t TAKEN_MARK = 16'h7a4e;
	localparam lisp_pkg::value_t FALL_MARK = 16'h0f11;

	logic clk;
	logic rst_n;
	lisp_pkg::instr_t instr_mem_read_value;
	lisp_pkg::word_t data_mem_read_value;
	lisp_pkg::addr_t instr_mem_address;
	lisp_pkg::addr_t data_mem_address;
	lisp_pkg::word_t data_mem_write_value;
	logic data_mem_write_enable;

	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;
	logic [31:0] lfsr_state = 32'h1819_b217;
	lisp_pkg::instr_t prog[$];
	lisp_pkg::opcode_t binary_ops[$] = '{lisp_pkg::OP_ADD, lisp_pkg::OP_SUB, lisp_pkg::OP_GTR,
		lisp_pkg::OP_GTE, lisp_pkg::OP_EQ, lisp_pkg::OP_NEQ, lisp_pkg::OP_AND, lisp_pkg::OP_OR,
		lisp_pkg::OP_XOR, lisp_pkg::OP_LSHIFT, lisp_pkg::OP_RSHIFT};

	lisp_core dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.instr_mem_read_value(instr_mem_read_value),
		.data_mem_read_value(data_mem_read_value),
		.instr_mem_address(instr_mem_address),
		.data_mem_address(data_mem_address),
		.data_mem_write_value(data_mem_write_value),
		.data_mem_write_enable(data_mem_write_enable)
	);

	tb_lisp_mem mem_i (
		.clk(clk),
		.instr_mem_address(instr_mem_address),
		.instr_mem_read_value(instr_mem_read_value),
		.data_mem_address(data_mem_address),
		.data_mem_write_value(data_mem_write_value),
		.data_mem_write_enable(data_mem_write_enable),
		.data_mem_read_value(data_mem_read_value)
	);

	initial
		clk = 1'b0;

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic lisp_pkg::value_t random_value(input int bits);
		lisp_pkg::value_t v;
		int i;
		v = '0;
		for (i = 0; i < bits; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[`LISP_VALUE_W-2:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic lisp_pkg::word_t plain_word(input lisp_pkg::value_t v);
		return {lisp_pkg::tag_t'(0), v};
	endfunction

	function automatic lisp_pkg::word_t random_word();
		lisp_pkg::tag_t t;
		t = lisp_pkg::tag_t'(random_value(3));
		if (t == '0)
			t = 3'd5;
		return {t, random_value(16)};
	endfunction

	// a is TOS (pushed last), b is next-on-stack
	function automatic lisp_pkg::value_t binary_result(input lisp_pkg::opcode_t op,
		input lisp_pkg::value_t a, input lisp_pkg::value_t b);
		lisp_pkg::value_t d;
		d = a - b;
		case (op)
			lisp_pkg::OP_ADD: return a + b;
			lisp_pkg::OP_SUB: return d;
			lisp_pkg::OP_GTR: return (d != '0 && !d[`LISP_VALUE_W-1]) ? 16'd1 : 16'd0;
			lisp_pkg::OP_GTE: return d[`LISP_VALUE_W-1] ? 16'd0 : 16'd1;
			lisp_pkg::OP_EQ: return (a == b) ? 16'd1 : 16'd0;
			lisp_pkg::OP_NEQ: return (a != b) ? 16'd1 : 16'd0;
			lisp_pkg::OP_AND: return a & b;
			lisp_pkg::OP_OR: return a | b;
			lisp_pkg::OP_XOR: return a ^ b;
			lisp_pkg::OP_LSHIFT: return (b >= 16'd16) ? 16'd0 : a << b[3:0];
			lisp_pkg::OP_RSHIFT: return (b >= 16'd16) ? 16'd0 : a >> b[3:0];
			default: return 16'd0;
		endcase
	endfunction

	task automatic check_word(input string name, input lisp_pkg::word_t expected,
		input lisp_pkg::word_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Mismatch in %s word: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_addr(input string name, input lisp_pkg::addr_t expected,
		input lisp_pkg::addr_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Mismatch in %s address: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic emit(input lisp_pkg::opcode_t op, input lisp_pkg::value_t param);
		prog.push_back({op, param});
	endtask

	// Leaves the core in reset with fresh memories
	task automatic hold_reset();
		int i;
		rst_n = 1'b0;
		prog.delete();
		for (i = 0; i < RESET_CYCLES; i++)
		begin
			@(negedge clk);
			if (data_mem_write_enable !== 1'b0)
			begin
				error_count++;
				$display("Data memory write enable was high during reset");
			end
		end
		mem_i.clear_rom();
		mem_i.fill_data();
	endtask

	task automatic run_program(input string name, input lisp_pkg::word_t expected);
		int i;
		int waited;
		bit found;
		lisp_pkg::addr_t loop_addr;
		emit(lisp_pkg::OP_PUSH, RESULT_ADDR);
		emit(lisp_pkg::OP_STORE, '0);
		loop_addr = lisp_pkg::addr_t'(prog.size());
		emit(lisp_pkg::OP_GOTO, loop_addr);
		for (i = 0; i < prog.size(); i++)
			mem_i.load_instr(lisp_pkg::addr_t'(i), prog[i]);
		rst_n = 1'b1;
		found = 1'b0;
		waited = 0;
		// First write below the stack is the result store
		while (!found && waited < RESULT_WAIT)
		begin
			@(negedge clk);
			waited++;
			if (data_mem_write_enable === 1'b1 && data_mem_address < STACK_FLOOR)
				found = 1'b1;
		end
		if (found)
		begin
			check_word(name, expected, data_mem_write_value);
			check_addr(name, RESULT_ADDR, data_mem_address);
			// Last STORE cycle presents the address of the GOTO after it
			check_addr($sformatf("%s next instruction", name), loop_addr, instr_mem_address);
		end
		else
		begin
			error_count++;
			$display("%s: no result write seen within %0d cycles", name, RESULT_WAIT);
		end
	endtask

	task automatic reset_and_push_store();
		lisp_pkg::value_t v;
		v = random_value(16);
		hold_reset();
		emit(lisp_pkg::OP_PUSH, v);
		run_program("push_store", plain_word(v));
	endtask

	task automatic binary_op_results();
		int k;
		int variant;
		lisp_pkg::opcode_t op;
		lisp_pkg::value_t x;
		lisp_pkg::value_t y;
		for (k = 0; k < binary_ops.size(); k++)
		begin
			op = binary_ops[k];
			for (variant = 0; variant < 2; variant++)
			begin
				y = random_value(16);
				// Shifts try a short amount, then one of 16 or more
				if (op == lisp_pkg::OP_LSHIFT || op == lisp_pkg::OP_RSHIFT)
					x = (variant == 0) ? random_value(4) : (random_value(16) | 16'h0010);
				else
					x = (variant == 0) ? random_value(16) : y;
				hold_reset();
				emit(lisp_pkg::OP_PUSH, x);
				emit(lisp_pkg::OP_PUSH, y);
				emit(op, '0);
				run_program($sformatf("%s variant %0d", op.name(), variant),
					plain_word(binary_result(op, y, x)));
			end
		end
	endtask

	task automatic stack_reuse();
		lisp_pkg::value_t a;
		lisp_pkg::value_t b;
		a = random_value(16);
		b = random_value(16);
		hold_reset();
		emit(lisp_pkg::OP_PUSH, a);
		emit(lisp_pkg::OP_DUP, '0);
		emit(lisp_pkg::OP_ADD, '0);
		run_program("dup_add", plain_word(a + a));
		hold_reset();
		emit(lisp_pkg::OP_PUSH, a);
		emit(lisp_pkg::OP_PUSH, b);
		emit(lisp_pkg::OP_POP, '0);
		run_program("pop", plain_word(a));
	endtask

	task automatic memory_reads();
		lisp_pkg::addr_t p;
		lisp_pkg::word_t w0;
		lisp_pkg::word_t w1;
		p = 16'h0200 + random_value(8);
		w0 = random_word();
		w1 = random_word();
		hold_reset();
		mem_i.load_data(p, w0);
		mem_i.load_data(p + 16'd1, w1);
		emit(lisp_pkg::OP_PUSH, p);
		emit(lisp_pkg::OP_LOAD, '0);
		run_program("load", w0);
		hold_reset();
		mem_i.load_data(p, w0);
		mem_i.load_data(p + 16'd1, w1);
		emit(lisp_pkg::OP_PUSH, p);
		emit(lisp_pkg::OP_REST, '0);
		run_program("rest", w1);
	endtask

	task automatic tag_read();
		lisp_pkg::addr_t p;
		lisp_pkg::word_t w;
		p = 16'h0400 + random_value(8);
		w = random_word();
		hold_reset();
		mem_i.load_data(p, w);
		emit(lisp_pkg::OP_PUSH, p);
		emit(lisp_pkg::OP_LOAD, '0);
		emit(lisp_pkg::OP_GETTAG, '0);
		run_program("gettag", plain_word(lisp_pkg::value_t'(w[`LISP_VALUE_W +: `LISP_TAG_W])));
	endtask

	// Taken path lands on address 4, fall-through pushes its own mark and skips it
	task automatic run_branch(input string name, input lisp_pkg::opcode_t br,
		input lisp_pkg::value_t cond, input lisp_pkg::value_t expected);
		hold_reset();
		if (br == lisp_pkg::OP_BFALSE)
			emit(lisp_pkg::OP_PUSH, cond);
		else
			emit(lisp_pkg::OP_NOP, '0);
		emit(br, 16'd4);
		emit(lisp_pkg::OP_PUSH, FALL_MARK);
		emit(lisp_pkg::OP_GOTO, 16'd5);
		emit(lisp_pkg::OP_PUSH, TAKEN_MARK);
		run_program(name, plain_word(expected));
	endtask

	task automatic branches();
		lisp_pkg::value_t cond;
		cond = random_value(16);
		if (cond == '0)
			cond = 16'd1;
		run_branch("goto", lisp_pkg::OP_GOTO, '0, TAKEN_MARK);
		run_branch("bfalse_zero", lisp_pkg::OP_BFALSE, '0, TAKEN_MARK);
		run_branch("bfalse_nonzero", lisp_pkg::OP_BFALSE, cond, FALL_MARK);
	endtask

	initial
	begin
		rst_n = 1'b0;
		reset_and_push_store();
		binary_op_results();
		stack_reuse();
		memory_reads();
		tag_read();
		branches();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_lisp_mem.sv
`default_nettype none

`include "lisp_settings.svh"

module tb_lisp_mem (
	input wire clk,
	input wire lisp_pkg::addr_t instr_mem_address,
	output lisp_pkg::instr_t instr_mem_read_value,
	input wire lisp_pkg::addr_t data_mem_address,
	input wire lisp_pkg::word_t data_mem_write_value,
	input wire data_mem_write_enable,
	output lisp_pkg::word_t data_mem_read_value
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROM_AW = 8;
	localparam int ROM_DEPTH = 1 << ROM_AW;
	localparam int DATA_AW = $clog2(`LISP_DATA_MEM_SIZE);

	lisp_pkg::instr_t rom [0:ROM_DEPTH-1];
	lisp_pkg::word_t ram [0:`LISP_DATA_MEM_SIZE-1];

	initial
	begin
		instr_mem_read_value = '0;
		data_mem_read_value = '0;
	end

	// Both memories answer one clock after the address
	always @(posedge clk)
	begin
		instr_mem_read_value <= rom[instr_mem_address[ROM_AW-1:0]];
	end

	// Read returns the old word when the same address is written
	always @(posedge clk)
	begin
		if (data_mem_write_enable)
			ram[data_mem_address[DATA_AW-1:0]] <= data_mem_write_value;
		data_mem_read_value <= ram[data_mem_address[DATA_AW-1:0]];
	end

	// Empty program space runs as NOP
	task automatic clear_rom();
		int i;
		for (i = 0; i < ROM_DEPTH; i++)
			rom[ROM_AW'(i)] = '0;
	endtask

	task automatic load_instr(input lisp_pkg::addr_t address, input lisp_pkg::instr_t instr);
		rom[address[ROM_AW-1:0]] = instr;
	endtask

	// Odd multiplier spreads every address bit into the word
	task automatic fill_data();
		int i;
		for (i = 0; i < `LISP_DATA_MEM_SIZE; i++)
			ram[DATA_AW'(i)] = lisp_pkg::word_t'(i * 32'h0001_9e37 + 32'h0000_5a5a);
	endtask

	task automatic load_data(input lisp_pkg::addr_t address, input lisp_pkg::word_t word);
		ram[address[DATA_AW-1:0]] = word;
	endtask

endmodule

`default_nettype wire

//--- lisp_core.sv
`default_nettype none

module lisp_core (
	input wire clk,
	input wire rst_n,
	input wire lisp_pkg::instr_t instr_mem_read_value,
	input wire lisp_pkg::word_t data_mem_read_value,
	output lisp_pkg::addr_t instr_mem_address,
	output lisp_pkg::addr_t data_mem_address,
	output lisp_pkg::word_t data_mem_write_value,
	output logic data_mem_write_enable
);

	lisp_pkg::opcode_t opcode;
	logic tos_zero;
	lisp_pkg::sp_sel_t sp_sel;
	lisp_pkg::tos_sel_t tos_sel;
	lisp_pkg::ip_sel_t ip_sel;
	lisp_pkg::ma_sel_t ma_sel;
	lisp_pkg::mw_sel_t mw_sel;
	lisp_pkg::op0_sel_t op0_sel;
	lisp_pkg::op1_sel_t op1_sel;
	lisp_pkg::opcode_t alu_op;

	stack_control control_i (
		.clk(clk),
		.rst_n(rst_n),
		.opcode(opcode),
		.tos_zero(tos_zero),
		.sp_sel(sp_sel),
		.tos_sel(tos_sel),
		.ip_sel(ip_sel),
		.ma_sel(ma_sel),
		.mw_sel(mw_sel),
		.op0_sel(op0_sel),
		.op1_sel(op1_sel),
		.alu_op(alu_op),
		.data_mem_write_enable(data_mem_write_enable)
	);

	stack_datapath datapath_i (
		.clk(clk),
		.rst_n(rst_n),
		.instr_mem_read_value(instr_mem_read_value),
		.data_mem_read_value(data_mem_read_value),
		.sp_sel(sp_sel),
		.tos_sel(tos_sel),
		.ip_sel(ip_sel),
		.ma_sel(ma_sel),
		.mw_sel(mw_sel),
		.op0_sel(op0_sel),
		.op1_sel(op1_sel),
		.alu_op(alu_op),
		.opcode(opcode),
		.tos_zero(tos_zero),
		.instr_mem_address(instr_mem_address),
		.data_mem_address(data_mem_address),
		.data_mem_write_value(data_mem_write_value)
	);

endmodule

`default_nettype wire

//--- stack_control.sv
`default_nettype none

module stack_control (
	input wire clk,
	input wire rst_n,
	input wire lisp_pkg::opcode_t opcode,
	input wire tos_zero,
	output lisp_pkg::sp_sel_t sp_sel,
	output lisp_pkg::tos_sel_t tos_sel,
	output lisp_pkg::ip_sel_t ip_sel,
	output lisp_pkg::ma_sel_t ma_sel,
	output lisp_pkg::mw_sel_t mw_sel,
	output lisp_pkg::op0_sel_t op0_sel,
	output lisp_pkg::op1_sel_t op1_sel,
	output lisp_pkg::opcode_t alu_op,
	output logic data_mem_write_enable
);

	lisp_pkg::state_t state;
	lisp_pkg::state_t state_next;

	always_comb
	begin
		state_next = state;
		sp_sel = lisp_pkg::SP_CURRENT;
		tos_sel = lisp_pkg::TOS_CURRENT;
		ip_sel = lisp_pkg::IP_CURRENT;
		ma_sel = lisp_pkg::MA_SP;
		mw_sel = lisp_pkg::MW_TOS;
		op0_sel = lisp_pkg::OP0_TOS;
		op1_sel = lisp_pkg::OP1_MEM;
		alu_op = opcode;
		data_mem_write_enable = 1'b0;

		case (state)
			// First address goes out right after reset
			lisp_pkg::STATE_FETCH:
			begin
				ip_sel = lisp_pkg::IP_NEXT;
				state_next = lisp_pkg::STATE_DECODE;
			end

			lisp_pkg::STATE_DECODE:
			begin
				case (opcode)
					lisp_pkg::OP_POP:
					begin
						ma_sel = lisp_pkg::MA_SP;
						sp_sel = lisp_pkg::SP_INCREMENT;
						state_next = lisp_pkg::STATE_PUSH_MEM_RESULT;
					end

					// TOS holds the address and is replaced by the data
					lisp_pkg::OP_LOAD:
					begin
						ma_sel = lisp_pkg::MA_TOS;
						state_next = lisp_pkg::STATE_PUSH_MEM_RESULT;
					end

					lisp_pkg::OP_REST:
					begin
						ma_sel = lisp_pkg::MA_ALU;
						op0_sel = lisp_pkg::OP0_TOS;
						op1_sel = lisp_pkg::OP1_ONE;
						alu_op = lisp_pkg::OP_ADD;
						state_next = lisp_pkg::STATE_PUSH_MEM_RESULT;
					end

					// Read the value to store from next-on-stack
					lisp_pkg::OP_STORE:
					begin
						ma_sel = lisp_pkg::MA_SP;
						state_next = lisp_pkg::STATE_GOT_STORE_VALUE;
					end

					lisp_pkg::OP_ADD,
					lisp_pkg::OP_SUB,
					lisp_pkg::OP_GTR,
					lisp_pkg::OP_GTE,
					lisp_pkg::OP_EQ,
					lisp_pkg::OP_NEQ,
					lisp_pkg::OP_AND,
					lisp_pkg::OP_OR,
					lisp_pkg::OP_XOR,
					lisp_pkg::OP_LSHIFT,
					lisp_pkg::OP_RSHIFT:
					begin
						ma_sel = lisp_pkg::MA_SP;
						state_next = lisp_pkg::STATE_GOT_NOS;
					end

					lisp_pkg::OP_GETTAG:
					begin
						tos_sel = lisp_pkg::TOS_TAG;
						ip_sel = lisp_pkg::IP_NEXT;
					end

					// Spill TOS to sp - 1, then load the immediate
					lisp_pkg::OP_PUSH:
					begin
						sp_sel = lisp_pkg::SP_DECREMENT;
						ma_sel = lisp_pkg::MA_ALU;
						op0_sel = lisp_pkg::OP0_SP;
						op1_sel = lisp_pkg::OP1_ONE;
						alu_op = lisp_pkg::OP_SUB;
						mw_sel = lisp_pkg::MW_TOS;
						data_mem_write_enable = 1'b1;
						tos_sel = lisp_pkg::TOS_PARAM;
						ip_sel = lisp_pkg::IP_NEXT;
					end

					// Same spill as PUSH, TOS left as is
					lisp_pkg::OP_DUP:
					begin
						sp_sel = lisp_pkg::SP_DECREMENT;
						ma_sel = lisp_pkg::MA_ALU;
						op0_sel = lisp_pkg::OP0_SP;
						op1_sel = lisp_pkg::OP1_ONE;
						alu_op = lisp_pkg::OP_SUB;
						mw_sel = lisp_pkg::MW_TOS;
						data_mem_write_enable = 1'b1;
						ip_sel = lisp_pkg::IP_NEXT;
					end

					lisp_pkg::OP_GOTO:
					begin
						ip_sel = lisp_pkg::IP_BRANCH;
					end

					// Branch now, refill TOS from the stack next cycle
					lisp_pkg::OP_BFALSE:
					begin
						ip_sel = tos_zero ? lisp_pkg::IP_BRANCH : lisp_pkg::IP_NEXT;
						sp_sel = lisp_pkg::SP_INCREMENT;
						ma_sel = lisp_pkg::MA_SP;
						state_next = lisp_pkg::STATE_BFALSE2;
					end

					default:
					begin
						ip_sel = lisp_pkg::IP_NEXT;
					end
				endcase
			end

			// NOS is on the read port; combine it with TOS
			lisp_pkg::STATE_GOT_NOS:
			begin
				op0_sel = lisp_pkg::OP0_TOS;
				op1_sel = lisp_pkg::OP1_MEM;
				alu_op = opcode;
				tos_sel = lisp_pkg::TOS_ALU;
				sp_sel = lisp_pkg::SP_INCREMENT;
				ip_sel = lisp_pkg::IP_NEXT;
				state_next = lisp_pkg::STATE_DECODE;
			end

			// Stored value also stays on TOS
			lisp_pkg::STATE_GOT_STORE_VALUE:
			begin
				data_mem_write_enable = 1'b1;
				ma_sel = lisp_pkg::MA_TOS;
				mw_sel = lisp_pkg::MW_MEM;
				tos_sel = lisp_pkg::TOS_MEM;
				sp_sel = lisp_pkg::SP_INCREMENT;
				ip_sel = lisp_pkg::IP_NEXT;
				state_next = lisp_pkg::STATE_DECODE;
			end

			lisp_pkg::STATE_PUSH_MEM_RESULT:
			begin
				tos_sel = lisp_pkg::TOS_MEM;
				ip_sel = lisp_pkg::IP_NEXT;
				state_next = lisp_pkg::STATE_DECODE;
			end

			// IP was already chosen in the first cycle
			lisp_pkg::STATE_BFALSE2:
			begin
				tos_sel = lisp_pkg::TOS_MEM;
				state_next = lisp_pkg::STATE_DECODE;
			end

			default:
			begin
				state_next = lisp_pkg::STATE_FETCH;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= lisp_pkg::STATE_FETCH;
		else
			state <= state_next;
	end

endmodule

`default_nettype wire

//--- stack_datapath.sv
`default_nettype none

`include "lisp_settings.svh"

module stack_datapath (
	input wire clk,
	input wire rst_n,
	input wire lisp_pkg::instr_t instr_mem_read_value,
	input wire lisp_pkg::word_t data_mem_read_value,
	input wire lisp_pkg::sp_sel_t sp_sel,
	input wire lisp_pkg::tos_sel_t tos_sel,
	input wire lisp_pkg::ip_sel_t ip_sel,
	input wire lisp_pkg::ma_sel_t ma_sel,
	input wire lisp_pkg::mw_sel_t mw_sel,
	input wire lisp_pkg::op0_sel_t op0_sel,
	input wire lisp_pkg::op1_sel_t op1_sel,
	input wire lisp_pkg::opcode_t alu_op,
	output lisp_pkg::opcode_t opcode,
	output logic tos_zero,
	output lisp_pkg::addr_t instr_mem_address,
	output lisp_pkg::addr_t data_mem_address,
	output lisp_pkg::word_t data_mem_write_value
);

	localparam lisp_pkg::addr_t SP_RESET =
		lisp_pkg::addr_t'(`LISP_DATA_MEM_SIZE - `LISP_SP_RESET_GAP);

	lisp_pkg::word_t top_of_stack;
	lisp_pkg::word_t top_of_stack_next;
	lisp_pkg::addr_t stack_pointer;
	lisp_pkg::addr_t stack_pointer_next;
	lisp_pkg::addr_t instruction_pointer;
	lisp_pkg::addr_t instruction_pointer_next;

	lisp_pkg::value_t param;
	lisp_pkg::tag_t tos_tag;
	lisp_pkg::value_t tos_value;
	lisp_pkg::value_t alu_op0;
	lisp_pkg::value_t alu_op1;
	lisp_pkg::value_t alu_result;

	assign opcode = lisp_pkg::opcode_t'(instr_mem_read_value[`LISP_VALUE_W +: `LISP_OPCODE_W]);
	assign param = instr_mem_read_value[`LISP_VALUE_W-1:0];

	assign tos_tag = top_of_stack[`LISP_VALUE_W +: `LISP_TAG_W];
	assign tos_value = top_of_stack[`LISP_VALUE_W-1:0];
	assign tos_zero = (tos_value == '0);

	always_comb
	begin
		case (op0_sel)
			lisp_pkg::OP0_SP:
				alu_op0 = lisp_pkg::value_t'(stack_pointer);
			default:
				alu_op0 = tos_value;
		endcase
	end

	always_comb
	begin
		case (op1_sel)
			lisp_pkg::OP1_ONE:
				alu_op1 = lisp_pkg::value_t'(1);
			default:
				alu_op1 = data_mem_read_value[`LISP_VALUE_W-1:0];
		endcase
	end

	stack_alu alu_i (
		.alu_op(alu_op),
		.op0(alu_op0),
		.op1(alu_op1),
		.result(alu_result)
	);

	always_comb
	begin
		case (sp_sel)
			lisp_pkg::SP_DECREMENT:
				stack_pointer_next = stack_pointer - 1'b1;
			lisp_pkg::SP_INCREMENT:
				stack_pointer_next = stack_pointer + 1'b1;
			default:
				stack_pointer_next = stack_pointer;
		endcase
	end

	// ALU results keep the tag already on TOS
	always_comb
	begin
		case (tos_sel)
			lisp_pkg::TOS_TAG:
				top_of_stack_next = {lisp_pkg::tag_t'(0), lisp_pkg::value_t'(tos_tag)};
			lisp_pkg::TOS_PARAM:
				top_of_stack_next = {lisp_pkg::tag_t'(0), param};
			lisp_pkg::TOS_ALU:
				top_of_stack_next = {tos_tag, alu_result};
			lisp_pkg::TOS_MEM:
				top_of_stack_next = data_mem_read_value;
			default:
				top_of_stack_next = top_of_stack;
		endcase
	end

	// Next IP also addresses the instruction memory
	always_comb
	begin
		case (ip_sel)
			lisp_pkg::IP_NEXT:
				instruction_pointer_next = instruction_pointer + 1'b1;
			lisp_pkg::IP_BRANCH:
				instruction_pointer_next = lisp_pkg::addr_t'(param);
			default:
				instruction_pointer_next = instruction_pointer;
		endcase
	end

	assign instr_mem_address = instruction_pointer_next;

	always_comb
	begin
		case (ma_sel)
			lisp_pkg::MA_TOS:
				data_mem_address = lisp_pkg::addr_t'(tos_value);
			lisp_pkg::MA_ALU:
				data_mem_address = lisp_pkg::addr_t'(alu_result);
			default:
				data_mem_address = stack_pointer;
		endcase
	end

	assign data_mem_write_value = (mw_sel == lisp_pkg::MW_MEM) ? data_mem_read_value : top_of_stack;

	// IP starts at all ones so the fetch cycle lands on address 0
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			top_of_stack <= '0;
			stack_pointer <= SP_RESET;
			instruction_pointer <= '1;
		end
		else
		begin
			top_of_stack <= top_of_stack_next;
			stack_pointer <= stack_pointer_next;
			instruction_pointer <= instruction_pointer_next;
		end
	end

endmodule

`default_nettype wire

//--- stack_alu.sv
`default_nettype none

`include "lisp_settings.svh"

module stack_alu (
	input wire lisp_pkg::opcode_t alu_op,
	input wire lisp_pkg::value_t op0,
	input wire lisp_pkg::value_t op1,
	output lisp_pkg::value_t result
);

	lisp_pkg::value_t diff;
	logic zero;
	logic negative;

	// All comparisons come from the one subtractor
	assign diff = op0 - op1;
	assign zero = (diff == '0);
	assign negative = diff[`LISP_VALUE_W-1];

	always_comb
	begin
		case (alu_op)
			lisp_pkg::OP_ADD:
				result = op0 + op1;
			lisp_pkg::OP_SUB:
				result = diff;
			lisp_pkg::OP_GTR:
				result = lisp_pkg::value_t'(!negative && !zero);
			lisp_pkg::OP_GTE:
				result = lisp_pkg::value_t'(!negative);
			lisp_pkg::OP_EQ:
				result = lisp_pkg::value_t'(zero);
			lisp_pkg::OP_NEQ:
				result = lisp_pkg::value_t'(!zero);
			lisp_pkg::OP_AND:
				result = op0 & op1;
			lisp_pkg::OP_OR:
				result = op0 | op1;
			lisp_pkg::OP_XOR:
				result = op0 ^ op1;
			// Whole op1 is the shift amount, so 16 and up clears the result
			lisp_pkg::OP_LSHIFT:
				result = op0 << op1;
			lisp_pkg::OP_RSHIFT:
				result = op0 >> op1;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- lisp_pkg.sv
`default_nettype none

`include "lisp_settings.svh"

package lisp_pkg;

	typedef logic [`LISP_VALUE_W-1:0] value_t;
	typedef logic [`LISP_TAG_W-1:0] tag_t;
	typedef logic [`LISP_TAG_W+`LISP_VALUE_W-1:0] word_t;
	typedef logic [`LISP_ADDR_W-1:0] addr_t;
	typedef logic [`LISP_OPCODE_W+`LISP_VALUE_W-1:0] instr_t;

	// Encodings follow the existing toolchain; unlisted codes run as NOP
	typedef enum logic [`LISP_OPCODE_W-1:0] {
		OP_NOP = 5'd0,
		OP_POP = 5'd3,
		OP_LOAD = 5'd4,
		OP_STORE = 5'd5,
		OP_ADD = 5'd6,
		OP_SUB = 5'd7,
		OP_REST = 5'd8,
		OP_GTR = 5'd9,
		OP_GTE = 5'd10,
		OP_EQ = 5'd11,
		OP_NEQ = 5'd12,
		OP_DUP = 5'd13,
		OP_GETTAG = 5'd14,
		OP_AND = 5'd16,
		OP_OR = 5'd17,
		OP_XOR = 5'd18,
		OP_LSHIFT = 5'd19,
		OP_RSHIFT = 5'd20,
		OP_PUSH = 5'd25,
		OP_GOTO = 5'd26,
		OP_BFALSE = 5'd27
	} opcode_t;

	typedef enum logic [2:0] {
		STATE_FETCH,
		STATE_DECODE,
		STATE_GOT_NOS,
		STATE_GOT_STORE_VALUE,
		STATE_PUSH_MEM_RESULT,
		STATE_BFALSE2
	} state_t;

	// Datapath mux selects
	typedef enum logic [1:0] {SP_CURRENT, SP_DECREMENT, SP_INCREMENT} sp_sel_t;

	typedef enum logic [2:0] {TOS_CURRENT, TOS_TAG, TOS_PARAM, TOS_ALU, TOS_MEM} tos_sel_t;

	typedef enum logic [1:0] {IP_CURRENT, IP_NEXT, IP_BRANCH} ip_sel_t;

	typedef enum logic [1:0] {MA_SP, MA_TOS, MA_ALU} ma_sel_t;

	typedef enum logic {MW_TOS, MW_MEM} mw_sel_t;

	typedef enum logic {OP0_TOS, OP0_SP} op0_sel_t;

	typedef enum logic {OP1_MEM, OP1_ONE} op1_sel_t;

endpackage

`default_nettype wire

//--- lisp_settings.svh
`ifndef LISP_SETTINGS_SVH
`define LISP_SETTINGS_SVH

// Tag field sits above the value field
`define LISP_VALUE_W 16
`define LISP_TAG_W 3

// Instruction and data addresses share one width
`define LISP_ADDR_W 16

// Opcode sits above a parameter as wide as a value
`define LISP_OPCODE_W 5

// Data memory depth in words
`define LISP_DATA_MEM_SIZE 8192

// Stack starts a few words below the top of data memory
`define LISP_SP_RESET_GAP 8

`endif
